//--- design/lifo_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LIFO stack package
// Depth, widths, payload word and command encoding
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package lifo_pkg;

  // Number of entries the stack can hold
  localparam int LIFO_DEPTH = 8;

  // Address of one entry in the storage array
  localparam int LIFO_ADDR_W = $clog2(LIFO_DEPTH);

  // The occupancy count must hold every value from 0 up to LIFO_DEPTH
  // inclusive, so it needs one more bit than the address
  localparam int LIFO_CNT_W = $clog2(LIFO_DEPTH + 1);

  // Width of one payload word
  localparam int LIFO_DATA_W = 16;

  // One payload word as carried on the host port and stored in the array
  typedef logic [LIFO_DATA_W-1:0] word_t;

  // Entry address driven by the pointer controller into the storage
  typedef logic [LIFO_ADDR_W-1:0] addr_t;

  // Host command encoding
  // Only one operation is carried per handshake
  typedef enum logic {
    OP_PUSH = 1'b0,
    OP_POP  = 1'b1
  } op_t;

endpackage : lifo_pkg

//--- design/lifo_ptr_ctl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LIFO stack pointer controller
// Occupancy count, full/empty flags and entry address
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lifo_ptr_ctl import lifo_pkg::*; (
  // Clock and reset
    input  logic  clk
  , input  logic  i_rst_n

  // Operation strobes, one cycle each and never both at once
  , input  logic  i_push
  , input  logic  i_pop

  // Storage control
  , output logic  o_mem_wen
  , output logic  o_mem_ren
  , output addr_t o_mem_addr

  // Registered status
  , output logic  o_full
  , output logic  o_empty
);

  // Registered controller state
  logic [LIFO_CNT_W-1:0] cnt_r;
  logic                  full_r;
  logic                  empty_r;

  // Next-state terms
  logic [LIFO_CNT_W-1:0] cnt_inc;
  logic [LIFO_CNT_W-1:0] cnt_dec;
  logic [LIFO_CNT_W-1:0] cnt_nxt;
  logic                  full_nxt;
  logic                  empty_nxt;
  logic                  state_upd;

  // The controller state only moves when an operation is strobed
  assign state_upd = i_push | i_pop;

  // The count is the index of the next free entry
  // The top of stack therefore sits one below it
  assign cnt_inc = cnt_r + LIFO_CNT_W'(1);
  assign cnt_dec = cnt_r - LIFO_CNT_W'(1);

  // A push grows the stack and a pop shrinks it
  assign cnt_nxt = i_push ? cnt_inc : cnt_dec;

  // Full is set by the push that fills the last entry
  // Any pop leaves room, so it clears the flag
  assign full_nxt = i_push & (cnt_nxt == LIFO_CNT_W'(LIFO_DEPTH));

  // Empty is set by the pop that removes the last entry
  // Any push clears it again
  assign empty_nxt = i_pop & (cnt_nxt == '0);

  // Count and flags settle on the edge that closes the strobe cycle
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt_r   <= '0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end else if (state_upd) begin
      cnt_r   <= cnt_nxt;
      full_r  <= full_nxt;
      empty_r <= empty_nxt;
    end
  end

  // The storage enables are the strobes themselves
  assign o_mem_wen = i_push;
  assign o_mem_ren = i_pop;

  // A push writes the free slot at the count
  // A pop reads the top entry just below it
  assign o_mem_addr = i_pop ? cnt_dec[LIFO_ADDR_W-1:0] : cnt_r[LIFO_ADDR_W-1:0];

  assign o_full  = full_r;
  assign o_empty = empty_r;

endmodule : lifo_ptr_ctl

//--- design/lifo_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LIFO entry storage
// Register file with synchronous write and registered read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lifo_ram import lifo_pkg::*; (
  // Clock
    input  logic  clk

  // Access control from the pointer controller
  , input  logic  i_wen
  , input  logic  i_ren
  , input  addr_t i_addr

  // Payload
  , input  word_t i_wdata
  , output word_t o_rdata
);

  // One word per stack entry
  word_t mem [LIFO_DEPTH];

  // Read data register
  word_t rdata_q;

  // The write lands on the same edge that ends the push strobe
  always_ff @(posedge clk) begin
    if (i_wen) begin
      mem[i_addr] <= i_wdata;
    end
  end

  // The read is registered, so data appears the cycle after i_ren
  // Between reads the register keeps the last word returned
  always_ff @(posedge clk) begin
    if (i_ren) begin
      rdata_q <= mem[i_addr];
    end
  end

  assign o_rdata = rdata_q;

endmodule : lifo_ram

//--- design/lifo_cmd_fsm.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LIFO command state machine
// Four-phase req/ack sequencing of one push or pop
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lifo_cmd_fsm import lifo_pkg::*; (
  // Clock and reset
    input  logic  clk
  , input  logic  i_rst_n

  // Host request side
  , input  logic  i_req
  , input  op_t   i_op

  // Registered status from the pointer controller
  , input  logic  i_full
  , input  logic  i_empty

  // Read data from the storage, valid the cycle after the pop strobe
  , input  word_t i_mem_rdata

  // Operation strobes to the pointer controller
  , output logic  o_push
  , output logic  o_pop

  // Host response side
  , output logic  o_ack
  , output logic  o_err
  , output word_t o_rdata
);

  // IDLE waits for a request, EXEC strobes, WAIT collects read data
  // and RESP holds the response until the host drops i_req
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_EXEC = 2'd1,
    ST_WAIT = 2'd2,
    ST_RESP = 2'd3
  } state_t;

  state_t state_r;

  // Decode of the current operation in EXEC
  logic   in_exec;
  logic   legal_push;
  logic   legal_pop;

  // Results carried from EXEC to the response
  logic   err_pend;
  logic   rd_pend;

  // Registered host outputs
  logic   ack_r;
  logic   err_r;
  word_t  rdata_r;

  assign in_exec = (state_r == ST_EXEC);

  // The flags are checked here, so the pointer controller only ever
  // sees operations that fit in the stack
  assign legal_push = in_exec & (i_op == OP_PUSH) & ~i_full;
  assign legal_pop  = in_exec & (i_op == OP_POP)  & ~i_empty;

  // Each strobe lasts exactly the one EXEC cycle
  assign o_push = legal_push;
  assign o_pop  = legal_pop;

  // Sequence and handshake
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_r  <= ST_IDLE;
      err_pend <= 1'b0;
      rd_pend  <= 1'b0;
      ack_r    <= 1'b0;
      err_r    <= 1'b0;
    end else begin
      case (state_r)
        ST_IDLE: begin
          // First IDLE cycle after a release drops ack
          // A new request is only taken once ack is low
          ack_r <= 1'b0;
          err_r <= 1'b0;
          if (i_req && !ack_r) begin
            state_r <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          // Neither strobe firing means the flags refused the operation
          err_pend <= ~(legal_push | legal_pop);
          rd_pend  <= legal_pop;
          state_r  <= ST_WAIT;
        end
        ST_WAIT: begin
          // The storage read register is loaded by now and is taken into rdata_r below
          state_r <= ST_RESP;
        end
        ST_RESP: begin
          // Ack and error go out together and stay up under back-pressure
          ack_r <= 1'b1;
          err_r <= err_pend;
          if (ack_r && !i_req) begin
            state_r <= ST_IDLE;
          end
        end
        default: begin
          state_r <= ST_IDLE;
        end
      endcase
    end
  end

  // Read data is taken only on a pop that was carried out
  // Pushes and refused pops keep the previous word on o_rdata
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rdata_r <= '0;
    end else if ((state_r == ST_WAIT) && rd_pend) begin
      rdata_r <= i_mem_rdata;
    end
  end

  assign o_ack   = ack_r;
  assign o_err   = err_r;
  assign o_rdata = rdata_r;

endmodule : lifo_cmd_fsm

//--- design/lifo_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LIFO stack top level
// Command FSM, pointer controller and entry storage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lifo_top import lifo_pkg::*; (
  // Clock and reset
    input  logic  clk
  , input  logic  i_rst_n

  // Host request, held stable until o_ack rises
  , input  logic  i_req
  , input  op_t   i_op
  , input  word_t i_wdata

  // Host response, valid while o_ack is high
  , output logic  o_ack
  , output logic  o_err
  , output word_t o_rdata

  // Stack status levels
  , output logic  o_full
  , output logic  o_empty
);

  // Strobes from the FSM to the pointer controller
  logic  push;
  logic  pop;

  // Storage control and return data
  logic  mem_wen;
  logic  mem_ren;
  addr_t mem_addr;
  word_t mem_rdata;

  // Sequences the handshake and gates each operation with the flags
  lifo_cmd_fsm u_cmd_fsm (
      .clk         (clk)
    , .i_rst_n     (i_rst_n)
    , .i_req       (i_req)
    , .i_op        (i_op)
    , .i_full      (o_full)
    , .i_empty     (o_empty)
    , .i_mem_rdata (mem_rdata)
    , .o_push      (push)
    , .o_pop       (pop)
    , .o_ack       (o_ack)
    , .o_err       (o_err)
    , .o_rdata     (o_rdata)
  );

  // Keeps occupancy and turns strobes into storage accesses
  lifo_ptr_ctl u_ptr_ctl (
      .clk        (clk)
    , .i_rst_n    (i_rst_n)
    , .i_push     (push)
    , .i_pop      (pop)
    , .o_mem_wen  (mem_wen)
    , .o_mem_ren  (mem_ren)
    , .o_mem_addr (mem_addr)
    , .o_full     (o_full)
    , .o_empty    (o_empty)
  );

  // Write data is taken straight from the host port
  lifo_ram u_ram (
      .clk     (clk)
    , .i_wen   (mem_wen)
    , .i_ren   (mem_ren)
    , .i_addr  (mem_addr)
    , .i_wdata (i_wdata)
    , .o_rdata (mem_rdata)
  );

endmodule : lifo_top

//--- tb/tb_clk_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset generator
// 20 ns clock, reset held low for the first 16 rising edges
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clk_gen (
    output logic o_clk
  , output logic o_rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // Half of the 20 ns clock period
  localparam int HALF_PERIOD = 10;

  // Rising edges seen with reset still asserted
  localparam int RST_CYCLES = 16;

  initial begin
    o_clk = 1'b0;
    forever begin
      #HALF_PERIOD o_clk = ~o_clk;
    end
  end

  // Release lands 2 ns after an edge, clear of the sampling instant
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    #2 o_rst_n = 1'b1;
  end

endmodule : tb_clk_gen

//--- tb/tb_lifo_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LIFO stack testbench
// Directed tests of the four-phase port against a queue model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_lifo_top import lifo_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // About 80 transactions of up to 8 cycles each, plus reset, with wide margin
  localparam int TIMEOUT_CYCLES = 3000;
  // Host inputs change this long after each rising edge
  localparam int DRIVE_DLY = 2;
  // Edges from the one that samples req high to ack high
  localparam int ACK_LATENCY = 3;
  // Edges from the one that samples req low to ack low
  localparam int REL_LATENCY = 1;
  // Bound on any single handshake wait
  localparam int WAIT_LIMIT = 20;

  logic  clk;
  logic  rst_n;
  logic  req;
  op_t   op;
  word_t wdata;
  logic  ack;
  logic  err;
  word_t rdata;
  logic  full;
  logic  empty;

  // Reference stack, the last element is the top of stack
  word_t  model[$];
  integer seed = 32'h814a_2718;
  int     error_cnt = 0;
  int     check_cnt = 0;
  int     test_cnt = 0;
  int     failed_tests = 0;
  int     cycle_cnt = 0;

  tb_clk_gen u_clk_gen (
      .o_clk   (clk)
    , .o_rst_n (rst_n)
  );

  lifo_top u_lifo_top (
      .clk     (clk)
    , .i_rst_n (rst_n)
    , .i_req   (req)
    , .i_op    (op)
    , .i_wdata (wdata)
    , .o_ack   (ack)
    , .o_err   (err)
    , .o_rdata (rdata)
    , .o_full  (full)
    , .o_empty (empty)
  );

  task automatic check_word(input string name, input word_t exp, input word_t act);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("MISMATCH %s: expected %h, actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("MISMATCH %s: expected %h, actual %h at %0t", name, exp, act, $time);
    end
  endtask

  // One line per finished test
  task automatic report_test(input string name, input int errs_at_start);
    test_cnt++;
    if (error_cnt == errs_at_start) begin
      $display("test %0d %s: pass", test_cnt, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: fail with %0d errors", test_cnt, name,
               error_cnt - errs_at_start);
    end
  endtask

  function automatic word_t rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[LIFO_DATA_W-1:0];
  endfunction

  function automatic op_t rand_op();
    logic [31:0] r;
    r = $random(seed);
    return r[0] ? OP_POP : OP_PUSH;
  endfunction

  // One full four-phase transaction that starts and ends at a drive point with ack low
  // The host keeps req up for hold extra cycles after ack rises
  task automatic do_op(input op_t op_in, input word_t data, input int hold,
                       output logic got_err, output word_t got_rdata);
    int n;
    req   = 1'b1;
    op    = op_in;
    wdata = data;
    // The next edge is the first one to sample req high
    @(posedge clk);
    #DRIVE_DLY;
    n = 0;
    while (!ack && n < WAIT_LIMIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      n++;
    end
    if (!ack) begin
      error_cnt++;
      $display("o_ack never rose within %0d cycles of the request", WAIT_LIMIT);
    end else if (n != ACK_LATENCY) begin
      error_cnt++;
      $display("o_ack rose %0d cycles after req was sampled high instead of %0d",
               n, ACK_LATENCY);
    end
    got_err   = err;
    got_rdata = rdata;
    // Under back-pressure the response has to stay up
    repeat (hold) begin
      @(posedge clk);
      #DRIVE_DLY;
      check_flag("o_ack", 1'b1, ack);
    end
    req = 1'b0;
    // This edge samples req low
    @(posedge clk);
    #DRIVE_DLY;
    n = 0;
    while (ack && n < WAIT_LIMIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      n++;
    end
    if (ack) begin
      error_cnt++;
      $display("o_ack stayed high for %0d cycles after req was dropped", WAIT_LIMIT);
    end else if (n != REL_LATENCY) begin
      error_cnt++;
      $display("o_ack fell %0d cycles after req was sampled low instead of %0d",
               n, REL_LATENCY);
    end
  endtask

  // One operation checked against the model for err, rdata and both flags
  task automatic stack_op(input op_t op_in, input word_t data, input int hold);
    logic  exp_err;
    logic  got_err;
    word_t got_rdata;
    word_t exp_rdata;
    // A push needs a free entry and a pop needs a stored one
    if (op_in == OP_PUSH) begin
      exp_err = (model.size() == LIFO_DEPTH);
    end else begin
      exp_err = (model.size() == 0);
    end
    do_op(op_in, data, hold, got_err, got_rdata);
    check_flag("o_err", exp_err, got_err);
    if (!exp_err) begin
      if (op_in == OP_PUSH) begin
        model.push_back(data);
      end else begin
        exp_rdata = model.pop_back();
        check_word("o_rdata", exp_rdata, got_rdata);
      end
    end
    check_flag("o_full", model.size() == LIFO_DEPTH, full);
    check_flag("o_empty", model.size() == 0, empty);
  endtask

  task automatic test_reset_state();
    int start;
    start = error_cnt;
    check_flag("o_empty", 1'b1, empty);
    check_flag("o_full", 1'b0, full);
    check_flag("o_ack", 1'b0, ack);
    check_flag("o_err", 1'b0, err);
    check_word("o_rdata", '0, rdata);
    report_test("reset state", start);
  endtask

  task automatic test_lifo_order();
    int start;
    start = error_cnt;
    repeat (5) begin
      stack_op(OP_PUSH, rand_word(), 0);
    end
    // Model pops give the words back newest first
    repeat (5) begin
      stack_op(OP_POP, '0, 0);
    end
    check_flag("o_empty", 1'b1, empty);
    report_test("lifo order", start);
  endtask

  task automatic test_full_reject();
    int start;
    start = error_cnt;
    repeat (LIFO_DEPTH) begin
      stack_op(OP_PUSH, rand_word(), 0);
    end
    check_flag("o_full", 1'b1, full);
    // The refused push leaves the model unchanged
    stack_op(OP_PUSH, rand_word(), 0);
    repeat (LIFO_DEPTH) begin
      stack_op(OP_POP, '0, 0);
    end
    report_test("full and rejected push", start);
  endtask

  task automatic test_empty_reject();
    int start;
    start = error_cnt;
    stack_op(OP_POP, '0, 0);
    check_flag("o_empty", 1'b1, empty);
    stack_op(OP_PUSH, rand_word(), 0);
    stack_op(OP_POP, '0, 0);
    report_test("rejected pop", start);
  endtask

  task automatic test_random_mix();
    int    start;
    op_t   rop;
    word_t rdat;
    start = error_cnt;
    repeat (40) begin
      rop  = rand_op();
      rdat = rand_word();
      stack_op(rop, rdat, 0);
    end
    report_test("random mix", start);
  endtask

  task automatic test_release();
    int start;
    start = error_cnt;
    // Start from an empty stack so a repeated push would show on the flags
    while (model.size() != 0) begin
      stack_op(OP_POP, '0, 0);
    end
    stack_op(OP_PUSH, rand_word(), 5);
    check_flag("o_empty", 1'b0, empty);
    // One pop empties the stack only if a single push happened
    stack_op(OP_POP, '0, 0);
    check_flag("o_empty", 1'b1, empty);
    report_test("handshake release", start);
  endtask

  // Guard against a hung handshake
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d clock cycles without completing", cycle_cnt);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    req   = 1'b0;
    op    = OP_PUSH;
    wdata = '0;
    @(posedge rst_n);
    @(posedge clk);
    #DRIVE_DLY;
    test_reset_state();
    test_lifo_order();
    test_full_reject();
    test_empty_reject();
    test_random_mix();
    test_release();
    $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
             test_cnt, failed_tests, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : tb_lifo_top

//--- lifo_top.f
design/lifo_pkg.sv
design/lifo_ptr_ctl.sv
design/lifo_ram.sv
design/lifo_cmd_fsm.sv
design/lifo_top.sv
tb/tb_clk_gen.sv
tb/tb_lifo_top.sv

//--- Makefile
# Verilator build and run of the LIFO stack testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_lifo_top
FILELIST  ?= lifo_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
PASS_TEXT ?= Everything OK

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# The binary is rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, not the exit code of the simulator
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx '$(PASS_TEXT)' $(LOG); then \
	  echo "simulation passed, log in $(LOG)"; \
	else \
	  echo "simulation did not pass, log in $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
